//--- mem_system.f
source/cache_pkg.sv
source/mem_pkg.sv
source/cache_way.sv
source/banked_mem.sv
source/cache_ctrl.sv
source/mem_system.sv
tests/tb_mem_system.sv

//--- Bender.yml
package:
  name: mem_system

sources:
  - source/cache_pkg.sv
  - source/mem_pkg.sv
  - source/cache_way.sv
  - source/banked_mem.sv
  - source/cache_ctrl.sv
  - source/mem_system.sv
  - target: test
    files:
      - tests/tb_mem_system.sv

//--- tests/tb_mem_system.sv
`default_nettype none

module tb_mem_system import cache_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int INDEX_BITS = 8;
	localparam int TIMEOUT = 64; // Cycles allowed for one access
	localparam int RANDOM_OPS = 400;

	logic clk;
	logic rst_n;
	logic started; // First request has been driven
	cpu_req_t req;
	cpu_rsp_t rsp;
	word_t shadow [addr_t]; // Every word written so far

	mem_system #(
		.INDEX_BITS(INDEX_BITS)
	) dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.rsp(rsp)
	);

	always #50 clk = ~clk;

	task automatic stop_with(input string line);
		$display("%s", line);
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	function automatic addr_t make_addr(input int tag, input int idx, input int word);
		return addr_t'((tag << (INDEX_BITS + OFFSET_W)) | (idx << OFFSET_W) | (word << 1));
	endfunction

	function automatic word_t expected_word(input addr_t addr);
		return shadow.exists(addr) ? shadow[addr] : '0; // Memory starts out as zero
	endfunction

	// One CPU access, held until done
	task automatic cpu_access(input logic is_wr, input addr_t addr, input word_t wdata,
		output word_t rdata, output logic hit);
		int cycles;
		logic got;
		cycles = 0;
		got = 1'b0;
		@(posedge clk);
		req.rd <= !is_wr;
		req.wr <= is_wr;
		req.addr <= addr;
		req.wdata <= wdata;
		started <= 1'b1;
		while (!got) begin
			@(posedge clk);
			cycles++;
			assert (cycles == 1 || rsp.stall) // First sampled edge is the accepting one
				else stop_with($sformatf("FAILED at %0d ns: stall low before done, address %h",
					$time, addr));
			if (rsp.done) begin
				got = 1'b1;
				rdata = rsp.rdata;
				hit = rsp.hit;
			end else if (cycles >= TIMEOUT) begin
				stop_with($sformatf("Timed out at %0d ns waiting %0d cycles for done, address %h",
					$time, TIMEOUT, addr));
			end
		end
		req.rd <= 1'b0;
		req.wr <= 1'b0;
		assert (!hit || cycles == 2)
			else stop_with($sformatf("FAILED at %0d ns: hit done %0d cycles after acceptance",
				$time, cycles - 1));
		if (is_wr) begin
			shadow[addr] = wdata;
		end else begin
			assert (rdata == expected_word(addr))
				else stop_with($sformatf("FAILED at %0d ns: read %h returned %h, expected %h",
					$time, addr, rdata, expected_word(addr)));
		end
	endtask

	assert property (@(posedge clk) disable iff (!rst_n)
		!started |-> !(rsp.done || rsp.stall || rsp.hit || rsp.err))
		else stop_with($sformatf("FAILED at %0d ns: response active before any request", $time));

	assert property (@(posedge clk) disable iff (!rst_n) !rsp.err)
		else stop_with($sformatf("FAILED at %0d ns: err flag raised", $time));

	assert property (@(posedge clk) disable iff (!rst_n) rsp.hit |-> rsp.done)
		else stop_with($sformatf("FAILED at %0d ns: hit without done", $time));

	assert property (@(posedge clk) disable iff (!rst_n) rsp.done |-> rsp.stall)
		else stop_with($sformatf("FAILED at %0d ns: done while not stalled", $time));

	assert property (@(posedge clk) disable iff (!rst_n) rsp.stall && !rsp.done |=> rsp.stall)
		else stop_with($sformatf("FAILED at %0d ns: stall dropped before done", $time));

	assert property (@(posedge clk) disable iff (!rst_n) rsp.done |=> !rsp.stall)
		else stop_with($sformatf("FAILED at %0d ns: stall still high after done", $time));

	assert property (@(posedge clk) disable iff (!rst_n)
		!rsp.stall && !(req.rd || req.wr) |=> !rsp.stall)
		else stop_with($sformatf("FAILED at %0d ns: stall without a request", $time));

	initial begin
		word_t rdata;
		logic hit;
		logic is_wr;
		addr_t addr;
		void'($urandom(32'hbe4b_969e));
		clk = 1'b0;
		rst_n = 1'b0;
		started = 1'b0;
		req = '0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		repeat (5) @(posedge clk); // Quiet stretch after reset

		addr = make_addr(1, 5, 2);
		cpu_access(1'b0, addr, '0, rdata, hit);
		assert (!hit) else stop_with($sformatf("FAILED at %0d ns: cold read hit", $time));
		cpu_access(1'b0, addr, '0, rdata, hit);
		assert (hit) else stop_with($sformatf("FAILED at %0d ns: re-read missed", $time));

		addr = make_addr(2, 9, 1);
		cpu_access(1'b1, addr, 16'h1234, rdata, hit);
		cpu_access(1'b0, addr, '0, rdata, hit);
		assert (hit) else stop_with($sformatf("FAILED at %0d ns: read after write missed", $time));
		addr = make_addr(2, 9, 3);
		cpu_access(1'b1, addr, 16'hbeef, rdata, hit);
		assert (hit) else stop_with($sformatf("FAILED at %0d ns: same line write missed", $time));
		cpu_access(1'b0, addr, '0, rdata, hit);

		// Three tags on one set, the third evicts a dirty line
		for (int i = 0; i < 3; i++) begin
			cpu_access(1'b1, make_addr(3 + i, 20, i), 16'h0a00 + 16'(i), rdata, hit);
			assert (!hit)
				else stop_with($sformatf("FAILED at %0d ns: new tag %0d hit", $time, 3 + i));
		end
		for (int i = 0; i < 3; i++) begin
			cpu_access(1'b0, make_addr(3 + i, 20, i), '0, rdata, hit);
		end

		for (int n = 0; n < RANDOM_OPS; n++) begin
			is_wr = ($urandom() % 2) == 1;
			addr = make_addr(int'($urandom() % 4), int'($urandom() % 4), int'($urandom() % 4));
			cpu_access(is_wr, addr, word_t'($urandom()), rdata, hit);
		end

		repeat (2) @(negedge clk);
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/mem_system.sv
`default_nettype none

module mem_system import cache_pkg::*, mem_pkg::*; #(
	parameter int unsigned INDEX_BITS = 8
) (
	input  logic     clk,
	input  logic     rst_n,
	input  cpu_req_t req,
	output cpu_rsp_t rsp
);

	way_cmd_t cmd; // Shared by both ways
	logic [1:0] way_en;
	way_status_t way0_status;
	way_status_t way1_status;
	mem_req_t mem_req;
	mem_rsp_t mem_rsp;

	cache_ctrl #(
		.INDEX_BITS(INDEX_BITS)
	) ctrl_i (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.rsp(rsp),
		.cmd(cmd),
		.way_en(way_en),
		.way0(way0_status),
		.way1(way1_status),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp)
	);

	cache_way #(
		.INDEX_BITS(INDEX_BITS)
	) way0_i (
		.clk(clk),
		.rst_n(rst_n),
		.en(way_en[0]),
		.cmd(cmd),
		.status(way0_status)
	);

	cache_way #(
		.INDEX_BITS(INDEX_BITS)
	) way1_i (
		.clk(clk),
		.rst_n(rst_n),
		.en(way_en[1]),
		.cmd(cmd),
		.status(way1_status)
	);

	banked_mem mem_i (
		.clk(clk),
		.rst_n(rst_n),
		.req(mem_req),
		.rsp(mem_rsp)
	);

endmodule

`default_nettype wire

//--- source/cache_ctrl.sv
`default_nettype none

module cache_ctrl import cache_pkg::*, mem_pkg::*; #(
	parameter int unsigned INDEX_BITS = 8
) (
	input  logic        clk,
	input  logic        rst_n,
	input  cpu_req_t    req,
	output cpu_rsp_t    rsp,
	output way_cmd_t    cmd,
	output logic [1:0]  way_en,
	input  way_status_t way0,
	input  way_status_t way1,
	output mem_req_t    mem_req,
	input  mem_rsp_t    mem_rsp
);

	localparam int unsigned TAG_BITS = ADDR_W - OFFSET_W - INDEX_BITS;

	typedef enum logic [2:0] {
		IDLE,
		COMPARE,
		ALLOC,
		WRITE_BACK,
		REQUEST,
		FILL,
		FINISH
	} state_t;

	state_t state;
	state_t next_state;
	addr_t addr_q;
	word_t wdata_q;
	logic wr_q;
	logic [1:0] cnt; // Word count for write back and requests
	logic [1:0] fill_cnt;
	logic victim_bit;
	logic victim_q;
	logic pick;
	logic err_q;
	logic err_set;
	logic fill_vld;
	word_t fill_data;
	logic [MEM_LATENCY-1:0] exp_q; // Read strobes still in flight
	logic accept;
	logic any_hit;
	word_t hit_rdata;
	way_status_t vic;
	mem_req_t mem_req_d;
	logic [INDEX_BITS-1:0] idx;
	logic [TAG_BITS-1:0] tag;

	assign idx = addr_q[INDEX_BITS+OFFSET_W-1:OFFSET_W];
	assign tag = addr_q[ADDR_W-1:INDEX_BITS+OFFSET_W];
	assign accept = state == IDLE && (req.rd || req.wr);
	assign any_hit = (way0.hit && way0.valid) || (way1.hit && way1.valid);
	assign hit_rdata = (way1.hit && way1.valid) ? way1.rdata : way0.rdata;
	assign vic = victim_q ? way1 : way0;
	assign pick = !way0.valid ? 1'b0 : (!way1.valid ? 1'b1 : victim_bit); // Invalid way first

	always_comb begin
		next_state = state;
		err_set = mem_rsp.rvalid != exp_q[MEM_LATENCY-1]; // Response off schedule
		way_en = 2'b00;
		cmd.index = index_t'(idx);
		cmd.tag = tag_t'(tag);
		cmd.offset = addr_q[OFFSET_W-1:0];
		cmd.comp = 1'b0;
		cmd.write = 1'b0;
		cmd.wdata = wdata_q;
		cmd.valid_in = 1'b1;
		mem_req_d.rd = 1'b0;
		mem_req_d.wr = 1'b0;
		mem_req_d.addr = {tag, idx, cnt, 1'b0};
		mem_req_d.wdata = vic.rdata;
		rsp.done = 1'b0;
		rsp.hit = 1'b0;
		rsp.stall = state != IDLE;
		rsp.rdata = hit_rdata;
		rsp.err = err_q;
		case (state)
			IDLE: begin
				if (req.rd || req.wr) begin
					next_state = COMPARE;
				end
			end
			COMPARE: begin
				way_en = 2'b11;
				cmd.comp = 1'b1;
				cmd.write = wr_q; // Merges the word on a hit
				rsp.done = any_hit;
				rsp.hit = any_hit;
				next_state = any_hit ? IDLE : ALLOC;
			end
			ALLOC: begin
				way_en = 2'b11; // Look at valid and dirty of the set
				if (pick ? (way1.valid && way1.dirty) : (way0.valid && way0.dirty)) begin
					next_state = WRITE_BACK;
				end else begin
					next_state = REQUEST;
				end
			end
			WRITE_BACK: begin
				way_en = victim_q ? 2'b10 : 2'b01;
				cmd.offset = {cnt, 1'b0};
				mem_req_d.wr = 1'b1;
				mem_req_d.addr = {vic.tag_out[TAG_BITS-1:0], idx, cnt, 1'b0};
				if (cnt == 2'd3) begin
					next_state = REQUEST;
				end
			end
			REQUEST: begin
				mem_req_d.rd = 1'b1;
				if (cnt == 2'd3) begin
					next_state = FILL;
				end
			end
			FILL: begin
				way_en = victim_q ? 2'b10 : 2'b01;
				cmd.offset = {fill_cnt, 1'b0};
				cmd.write = fill_vld; // One word per returned read
				cmd.wdata = fill_data;
				if (fill_vld && fill_cnt == 2'd3) begin
					next_state = FINISH;
				end
			end
			FINISH: begin
				way_en = 2'b11;
				cmd.comp = 1'b1;
				cmd.write = wr_q;
				rsp.done = 1'b1;
				next_state = IDLE;
			end
			default: begin
				err_set = 1'b1;
				next_state = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q <= req.addr;
			wdata_q <= req.wdata;
		end
		if (state == ALLOC) begin
			victim_q <= pick;
		end
		fill_data <= mem_rsp.rdata;
		mem_req <= mem_req_d; // Registered strobes toward memory
		if (!rst_n) begin
			mem_req.rd <= 1'b0;
			mem_req.wr <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			wr_q <= 1'b0;
			cnt <= '0;
			fill_cnt <= '0;
			victim_bit <= 1'b0;
			err_q <= 1'b0;
			fill_vld <= 1'b0;
			exp_q <= '0;
		end else begin
			state <= next_state;
			fill_vld <= mem_rsp.rvalid;
			exp_q <= {exp_q[MEM_LATENCY-2:0], mem_req.rd};
			if (accept) begin
				wr_q <= req.wr;
			end
			if (state == COMPARE) begin
				victim_bit <= !victim_bit; // Alternates on every compare
			end
			cnt <= (state == WRITE_BACK || state == REQUEST) ? cnt + 2'd1 : 2'd0;
			if (state != FILL) begin
				fill_cnt <= '0;
			end else if (fill_vld) begin
				fill_cnt <= fill_cnt + 2'd1;
			end
			if (err_set) begin
				err_q <= 1'b1;
			end else if (accept) begin
				err_q <= 1'b0; // Held until the next request
			end
		end
	end

endmodule

`default_nettype wire

//--- source/banked_mem.sv
`default_nettype none

module banked_mem import cache_pkg::*, mem_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  mem_req_t req,
	output mem_rsp_t rsp
);

	localparam int unsigned ROW_BITS = ADDR_W - 1 - BANK_BITS; // Word address above bank bits
	localparam int unsigned ROWS = 1 << ROW_BITS;

	logic [BANK_BITS-1:0] sel;
	logic [ROW_BITS-1:0] row;
	logic [NUM_BANKS-1:0] s2_vld;
	word_t s2_data [NUM_BANKS];

	assign sel = req.addr[BANK_BITS:1]; // Neighbouring words go to different banks
	assign row = req.addr[ADDR_W-1:BANK_BITS+1];

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		word_t bank_arr [ROWS];
		logic s1_vld;
		logic [ROW_BITS-1:0] s1_row;

		initial begin
			for (int i = 0; i < ROWS; i++) begin
				bank_arr[i] = '0; // Memory powers up as zero
			end
		end

		always @(posedge clk) begin
			if (req.wr && sel == BANK_BITS'(b)) begin
				bank_arr[row] <= req.wdata;
			end
			s2_data[b] <= bank_arr[s1_row]; // Second stage holds the read word
		end

		always_ff @(posedge clk) begin
			s1_row <= row;
			if (!rst_n) begin
				s1_vld <= 1'b0;
				s2_vld[b] <= 1'b0;
			end else begin
				s1_vld <= req.rd && sel == BANK_BITS'(b);
				s2_vld[b] <= s1_vld;
			end
		end
	end

	// One read strobe per cycle, so at most one bank returns data
	always_comb begin
		rsp.rvalid = |s2_vld;
		rsp.rdata = '0;
		for (int b = 0; b < NUM_BANKS; b++) begin
			if (s2_vld[b]) begin
				rsp.rdata = s2_data[b];
			end
		end
	end

endmodule

`default_nettype wire

//--- source/cache_way.sv
`default_nettype none

module cache_way import cache_pkg::*; #(
	parameter int unsigned INDEX_BITS = 8
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        en,
	input  way_cmd_t    cmd,
	output way_status_t status
);

	localparam int unsigned SETS = 1 << INDEX_BITS;
	localparam int unsigned TAG_BITS = ADDR_W - OFFSET_W - INDEX_BITS;

	logic [TAG_BITS-1:0] tag_arr [SETS];
	word_t data_arr [SETS][LINE_WORDS];
	logic [SETS-1:0] valid_arr;
	logic [SETS-1:0] dirty_arr;
	logic [INDEX_BITS-1:0] set_idx;
	logic [1:0] word_sel;
	logic match;
	logic wr_word;

	assign set_idx = cmd.index[INDEX_BITS-1:0];
	assign word_sel = cmd.offset[2:1]; // Words sit on even byte offsets
	assign match = tag_arr[set_idx] == cmd.tag[TAG_BITS-1:0];

	// Compare writes only land on a valid hit, access writes always land
	assign wr_word = en && cmd.write && (!cmd.comp || (valid_arr[set_idx] && match));

	always_comb begin
		status.hit = en && cmd.comp && match;
		status.valid = valid_arr[set_idx];
		status.dirty = dirty_arr[set_idx];
		status.tag_out = tag_t'(tag_arr[set_idx]);
		status.rdata = data_arr[set_idx][word_sel];
	end

	always_ff @(posedge clk) begin
		if (wr_word) begin
			data_arr[set_idx][word_sel] <= cmd.wdata;
		end
		if (en && cmd.write && !cmd.comp) begin
			tag_arr[set_idx] <= cmd.tag[TAG_BITS-1:0]; // Fill takes the new tag
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_arr <= '0;
			dirty_arr <= '0;
		end else if (wr_word) begin
			if (!cmd.comp) begin
				valid_arr[set_idx] <= cmd.valid_in;
				dirty_arr[set_idx] <= 1'b0; // Line matches memory after a fill
			end else begin
				dirty_arr[set_idx] <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/mem_pkg.sv
`default_nettype none

package mem_pkg;

	localparam int unsigned NUM_BANKS = 4;
	localparam int unsigned BANK_BITS = $clog2(NUM_BANKS);
	localparam int unsigned MEM_LATENCY = 2; // Read strobe to rvalid, in cycles

	typedef struct packed {
		logic rd; // One cycle strobe
		logic wr; // One cycle strobe
		cache_pkg::addr_t addr;
		cache_pkg::word_t wdata;
	} mem_req_t;

	typedef struct packed {
		logic rvalid;
		cache_pkg::word_t rdata;
	} mem_rsp_t;

endpackage

`default_nettype wire

//--- source/cache_pkg.sv
`default_nettype none

package cache_pkg;

	localparam int unsigned ADDR_W = 16;
	localparam int unsigned WORD_W = 16;
	localparam int unsigned OFFSET_W = 3; // Byte offset in a line
	localparam int unsigned LINE_WORDS = 4;
	localparam int unsigned MAX_INDEX_BITS = 8;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [OFFSET_W-1:0] offset_t;
	typedef logic [MAX_INDEX_BITS-1:0] index_t; // Zero extended set index
	typedef logic [ADDR_W-OFFSET_W-1:0] tag_t; // Zero extended, width set by INDEX_BITS

	typedef struct packed {
		logic rd;
		logic wr;
		addr_t addr;
		word_t wdata;
	} cpu_req_t;

	typedef struct packed {
		logic done; // One cycle pulse
		logic stall;
		logic hit; // Valid with done
		word_t rdata;
		logic err;
	} cpu_rsp_t;

	typedef struct packed {
		index_t index;
		tag_t tag;
		offset_t offset;
		logic comp; // Compare mode
		logic write;
		word_t wdata;
		logic valid_in;
	} way_cmd_t;

	typedef struct packed {
		logic hit; // Tag match in compare mode
		logic valid;
		logic dirty;
		tag_t tag_out; // Stored tag for the write back address
		word_t rdata;
	} way_status_t;

endpackage

`default_nettype wire
